// File: verilog.f
+incdir+include
verilog/cryPixelPkg.sv
verilog/videoStreamPkg.sv
verilog/pipeStage.sv
verilog/cryColorRom.sv
verilog/intensityScaler.sv
verilog/cryLookupPipe.sv
verilog/cryToRgb.sv
dv/cryToRgb_assert.sv
dv/cryToRgb_tb.sv

// File: Makefile
SIM        = verilator
TOP        = cryToRgb_tb
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only --timing --assert

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the simulator exits with a failing status on any $fatal or assertion error
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/cryToRgb_tb.sv
// testbench for the CRY to RGB colour stage with reference model, scoreboard and directed tests
`default_nettype none

`include "cry_config.svh"

module cryToRgb_tb
	import cryPixelPkg::*;
	import videoStreamPkg::*;
();

	localparam int RESET_CYCLES = 8;
	localparam int FULL_BEATS = 256;
	localparam int RANDOM_BEATS = 200;
	// full sweep, latency beat, scaling and back-pressure beats, each allowed two cycles
	localparam int TIMEOUT_CYCLES =
		2 * (FULL_BEATS + 1 + 2 * RANDOM_BEATS) + `CRY_PIPE_LATENCY + RESET_CYCLES;

	logic     sys_clk = 1'b0;
	logic     rstN;
	logic     inValid;
	logic     inReady;
	cryBeat_t inBeat;
	logic     outValid;
	logic     outReady;
	rgbBeat_t outBeat;

	rgbBeat_t    expectQ [$]; // expected output beats in input order
	rgbBeat_t    expectedOut;
	string       testName;
	logic [31:0] rngState;
	logic        randomReady; // outReady follows the random stream when set
	int          cycleCount = 0;
	int          acceptCount = 0;
	int          lastAcceptCycle = 0;
	int          lastOutCycle = 0;

	cryToRgb dut_i (
		.sys_clk  (sys_clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.inBeat   (inBeat),
		.outValid (outValid),
		.outReady (outReady),
		.outBeat  (outBeat)
	);

	always #50 sys_clk = ~sys_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state ^ (state << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	function automatic cryBeat_t randomBeat();
		logic [31:0] r;
		r = nextRandom();
		return cryBeat_t'(r[16:0]);
	endfunction

	// channel * intensity / 255 to the nearest integer, a half rounds up
	function automatic logic [7:0] scaleChannel(input int level, input int intensity);
		return 8'((2 * level * intensity + 255) / 510);
	endfunction

	function automatic rgbBeat_t referenceBeat(input cryBeat_t beat);
		int red;
		int blue;
		int green;
		rgbBeat_t result;
		red = 17 * int'(beat.pixel.redIdx);
		blue = 17 * int'(beat.pixel.cyanIdx);
		green = 255 - (red + blue) / 2;
		result.rgb.red = scaleChannel(red, int'(beat.pixel.intensity));
		result.rgb.green = scaleChannel(green, int'(beat.pixel.intensity));
		result.rgb.blue = scaleChannel(blue, int'(beat.pixel.intensity));
		result.endOfLine = beat.endOfLine;
		return result;
	endfunction

	task automatic reportMismatch(input logic [31:0] expected, input logic [31:0] actual);
		$display("FAIL %s: expected %0h actual %0h", testName, expected, actual);
		$display("*** TEST FAILED ***");
	endtask

	task automatic reportProblem(input string reason);
		$display("ERROR in %s: %s", testName, reason);
		$display("*** TEST FAILED ***");
	endtask

	// scoreboard, cycle count and timeout share one process so their order is fixed
	always @(posedge sys_clk) begin
		if (rstN && inValid && inReady) begin
			expectQ.push_back(referenceBeat(inBeat));
			acceptCount++;
			lastAcceptCycle = cycleCount;
		end
		if (rstN && outValid && outReady) begin
			assert (expectQ.size() != 0) else begin
				reportProblem("an output beat arrived that matches no input beat");
				$fatal(1);
			end
			expectedOut = expectQ.pop_front();
			assert (outBeat == expectedOut) else begin
				reportMismatch({7'd0, expectedOut}, {7'd0, outBeat});
				$fatal(1);
			end
			lastOutCycle = cycleCount;
		end
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

	task automatic driveReady();
		logic [31:0] r;
		if (randomReady) begin
			r = nextRandom();
			outReady = r[0];
		end else begin
			outReady = 1'b1;
		end
	endtask

	task automatic stepCycle();
		@(posedge sys_clk);
		@(negedge sys_clk);
		driveReady();
	endtask

	// holds the beat until the scoreboard has seen it accepted
	task automatic sendBeat(input cryBeat_t beat, output int stalls);
		int startCount;
		startCount = acceptCount;
		stalls = -1;
		inValid = 1'b1;
		inBeat = beat;
		while (acceptCount == startCount) begin
			stepCycle();
			stalls++;
		end
		inValid = 1'b0;
	endtask

	task automatic drainPipe();
		while (expectQ.size() != 0) begin
			stepCycle();
		end
	endtask

	task automatic testReset();
		testName = "testReset";
		stepCycle();
		assert (outValid == 1'b0) else begin
			reportMismatch(32'd0, {31'd0, outValid});
			$fatal(1);
		end
		assert (inReady == 1'b1) else begin
			reportMismatch(32'd1, {31'd0, inReady});
			$fatal(1);
		end
	endtask

	task automatic testFullIntensity();
		cryBeat_t beat;
		int stalls;
		testName = "testFullIntensity";
		for (int idx = 0; idx < FULL_BEATS; idx++) begin
			beat.pixel.cyanIdx = idx[7:4];
			beat.pixel.redIdx = idx[3:0];
			beat.pixel.intensity = 8'hFF;
			beat.endOfLine = (idx % 16 == 15); // sixteen pixels to a line
			sendBeat(beat, stalls);
		end
		drainPipe();
	endtask

	task automatic testLatency();
		cryBeat_t beat;
		int stalls;
		testName = "testLatency";
		beat = '{pixel: '{cyanIdx: 4'h3, redIdx: 4'hC, intensity: 8'd200}, endOfLine: 1'b1};
		sendBeat(beat, stalls);
		drainPipe();
		assert (lastOutCycle - lastAcceptCycle == `CRY_PIPE_LATENCY) else begin
			reportMismatch(32'(`CRY_PIPE_LATENCY), 32'(lastOutCycle - lastAcceptCycle));
			$fatal(1);
		end
	endtask

	task automatic testScaling();
		cryBeat_t beat;
		int stalls;
		testName = "testScaling";
		for (int n = 0; n < RANDOM_BEATS; n++) begin
			beat = randomBeat();
			case (n % 8) // black and half intensity get regular turns
				0: beat.pixel.intensity = 8'd0;
				1: beat.pixel.intensity = 8'd128;
				default: ;
			endcase
			sendBeat(beat, stalls);
			assert (stalls == 0) else begin
				reportProblem("inReady fell while outReady was held high");
				$fatal(1);
			end
		end
		drainPipe();
	endtask

	task automatic testBackPressure();
		int stalls;
		int totalStalls;
		testName = "testBackPressure";
		totalStalls = 0;
		randomReady = 1'b1;
		for (int n = 0; n < RANDOM_BEATS; n++) begin
			sendBeat(randomBeat(), stalls);
			totalStalls += stalls;
		end
		drainPipe();
		randomReady = 1'b0;
		outReady = 1'b1;
		assert (totalStalls > 0) else begin
			reportProblem("toggling outReady never stalled the input");
			$fatal(1);
		end
	endtask

	initial begin
		rstN = 1'b0;
		inValid = 1'b0;
		inBeat = '0;
		outReady = 1'b1;
		randomReady = 1'b0;
		rngState = 32'd31;
		testName = "reset";
		repeat (RESET_CYCLES) @(posedge sys_clk);
		@(negedge sys_clk);
		rstN = 1'b1;
		testReset();
		testFullIntensity();
		testLatency();
		testScaling();
		testBackPressure();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/cryToRgb_assert.sv
// bound checks on the CRY to RGB output handshake, reset and latency
`default_nettype none

`include "cry_config.svh"

module cryToRgb_assert
	import videoStreamPkg::*;
(
	input logic     sys_clk,
	input logic     rstN,
	input logic     inValid,
	input logic     inReady,
	input logic     outValid,
	input logic     outReady,
	input rgbBeat_t outBeat
);

	int inFlight;    // beats accepted but not yet delivered
	int quietCycles; // cycles with beats in flight while outValid stays low

	always_ff @(posedge sys_clk) begin
		if (!rstN) begin
			inFlight <= 0;
			quietCycles <= 0;
		end else begin
			inFlight <= inFlight + int'(inValid && inReady) - int'(outValid && outReady);
			quietCycles <= (inFlight != 0 && !outValid) ? quietCycles + 1 : 0;
		end
	end

	// nothing is presented straight out of reset
	resetClearsOutput: assert property (@(posedge sys_clk) !rstN |=> !outValid)
		else $error("outValid was high in the cycle after reset");

	stallHoldsBeat: assert property (@(posedge sys_clk) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outBeat))
		else $error("output beat dropped or changed while stalled");

	// the oldest beat in flight sees outValid low on at most latency minus one edges
	beatArrivesInTime: assert property (@(posedge sys_clk) disable iff (!rstN)
		inFlight != 0 && !outValid |-> quietCycles < `CRY_PIPE_LATENCY - 1)
		else $error("accepted beat did not reach the output within the pipeline latency");

endmodule

bind cryToRgb cryToRgb_assert assert_i (
	.sys_clk  (sys_clk),
	.rstN     (rstN),
	.inValid  (inValid),
	.inReady  (inReady),
	.outValid (outValid),
	.outReady (outReady),
	.outBeat  (outBeat)
);

`default_nettype wire

// File: verilog/cryToRgb.sv
// CRY to RGB888 colour stage with registered input and output handshakes
`default_nettype none

module cryToRgb
	import videoStreamPkg::*;
(
	input  logic     sys_clk,
	input  logic     rstN,
	input  logic     inValid,
	output logic     inReady,
	input  cryBeat_t inBeat,
	output logic     outValid,
	input  logic     outReady,
	output rgbBeat_t outBeat
);

	logic     stagedValid; // input stage to lookup pipe
	logic     stagedReady;
	cryBeat_t stagedBeat;
	logic     convValid;   // lookup pipe to output stage
	logic     convReady;
	rgbBeat_t convBeat;

	pipeStage #(.payload_t(cryBeat_t)) inStage_i (
		.sys_clk  (sys_clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.inData   (inBeat),
		.outValid (stagedValid),
		.outReady (stagedReady),
		.outData  (stagedBeat)
	);

	cryLookupPipe lookup_i (
		.sys_clk  (sys_clk),
		.rstN     (rstN),
		.inValid  (stagedValid),
		.inReady  (stagedReady),
		.inBeat   (stagedBeat),
		.outValid (convValid),
		.outReady (convReady),
		.outBeat  (convBeat)
	);

	pipeStage #(.payload_t(rgbBeat_t)) outStage_i (
		.sys_clk  (sys_clk),
		.rstN     (rstN),
		.inValid  (convValid),
		.inReady  (convReady),
		.inData   (convBeat),
		.outValid (outValid),
		.outReady (outReady),
		.outData  (outBeat)
	);

endmodule

`default_nettype wire

// File: verilog/cryLookupPipe.sv
// two-stage CRY to RGB core: table lookup, then intensity scaling
`default_nettype none

`include "cry_config.svh"

module cryLookupPipe
	import cryPixelPkg::*;
	import videoStreamPkg::*;
(
	input  logic     sys_clk,
	input  logic     rstN,
	input  logic     inValid,
	output logic     inReady,
	input  cryBeat_t inBeat,
	output logic     outValid,
	input  logic     outReady,
	output rgbBeat_t outBeat
);

	logic                         advance;
	logic                         lookupValid;
	logic                         scaleValid;
	logic [7:0]                   colorByte;
	logic [`CRY_CHANNEL_BITS-1:0] lookupIntensity; // rides along with the table read
	logic                         lookupEol;
	logic                         scaleEol;
	logic [7:0]                   level [3];
	logic [`CRY_CHANNEL_BITS-1:0] scaled [3];

	// the whole pipe moves together, so only the last stage decides
	assign advance = !scaleValid || outReady;
	assign inReady = advance;

	assign colorByte = {inBeat.pixel.cyanIdx, inBeat.pixel.redIdx};

	always_ff @(posedge sys_clk) begin
		if (!rstN) begin
			lookupValid <= 1'b0;
			scaleValid <= 1'b0;
		end else if (advance) begin
			lookupValid <= inValid;
			scaleValid <= lookupValid;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (advance) begin
			lookupIntensity <= inBeat.pixel.intensity;
			lookupEol <= inBeat.endOfLine;
			scaleEol <= lookupEol;
		end
	end

	// one table and one scaler per channel, indexed by cryChannel_t
	for (genvar ch = 0; ch < 3; ch++) begin : gChannel
		cryColorRom #(.channel(cryChannel_t'(ch))) rom_i (
			.sys_clk  (sys_clk),
			.enable   (advance),
			.colorIdx (colorByte),
			.level    (level[ch])
		);

		intensityScaler scaler_i (
			.sys_clk   (sys_clk),
			.enable    (advance),
			.level     (level[ch]),
			.intensity (lookupIntensity),
			.scaled    (scaled[ch])
		);
	end

	assign outValid = scaleValid;
	assign outBeat = '{
		rgb: '{red: scaled[chanRed], green: scaled[chanGreen], blue: scaled[chanBlue]},
		endOfLine: scaleEol
	};

endmodule

`default_nettype wire

// File: verilog/intensityScaler.sv
// multiplies a channel by intensity/255 with round to nearest, registered
`default_nettype none

`include "cry_config.svh"

module intensityScaler (
	input  logic                         sys_clk,
	input  logic                         enable,
	input  logic [`CRY_CHANNEL_BITS-1:0] level,
	input  logic [`CRY_CHANNEL_BITS-1:0] intensity,
	output logic [`CRY_CHANNEL_BITS-1:0] scaled
);

	localparam int W = `CRY_CHANNEL_BITS;

	logic [2*W-1:0] product;
	logic [2*W-1:0] biased;
	logic [2*W-1:0] corrected;

	assign product = level * intensity;
	assign biased = product + (2*W)'(1 << (W - 1)); // add half of 256 for rounding

	// x/255 is close to (x + x/256)/256, exact here once the rounding bias is in
	assign corrected = biased + (biased >> W);

	always_ff @(posedge sys_clk) begin
		if (enable) begin
			scaled <= W'(corrected >> W);
		end
	end

endmodule

`default_nettype wire

// File: verilog/cryColorRom.sv
// full-intensity colour table for one RGB channel behind a registered read port
`default_nettype none

`include "cry_config.svh"

module cryColorRom
	import cryPixelPkg::*;
#(
	parameter cryChannel_t channel = chanRed
) (
	input  logic       sys_clk,
	input  logic       enable,
	input  logic [7:0] colorIdx,
	output logic [7:0] level
);

	logic [7:0] colorTable [0:`CRY_TABLE_DEPTH-1];

	// channel value at full intensity for one colour byte
	function automatic logic [7:0] tableEntry(input logic [7:0] colorByte);
		logic [7:0] red;
		logic [7:0] blue;
		logic [8:0] sum;
		red = {colorByte[3:0], colorByte[3:0]}; // nibble repeated is 17 times the index
		blue = {colorByte[7:4], colorByte[7:4]};
		sum = red + blue;
		case (channel)
			chanRed:  tableEntry = red;
			chanBlue: tableEntry = blue;
			// green takes whatever red and blue leave, halved
			default:  tableEntry = 8'hFF - 8'(sum >> 1);
		endcase
	endfunction

	initial begin
		for (int idx = 0; idx < `CRY_TABLE_DEPTH; idx++) begin
			colorTable[idx] = tableEntry(8'(idx));
		end
	end

	// output holds its last value while the pipeline is stalled
	always_ff @(posedge sys_clk) begin
		if (enable) begin
			level <= colorTable[colorIdx];
		end
	end

endmodule

`default_nettype wire

// File: verilog/pipeStage.sv
// single valid/ready register slice for any payload type
`default_nettype none

module pipeStage #(
	parameter type payload_t = logic
) (
	input  logic     sys_clk,
	input  logic     rstN,
	input  logic     inValid,
	output logic     inReady,
	input  payload_t inData,
	output logic     outValid,
	input  logic     outReady,
	output payload_t outData
);

	logic     full;
	payload_t held;
	logic     take;

	// an empty slot or a draining slot can take a new beat
	assign inReady = !full || outReady;
	assign take = inValid && inReady;

	always_ff @(posedge sys_clk) begin
		if (!rstN) begin
			full <= 1'b0;
		end else if (take) begin
			full <= 1'b1; // refill also covers the same-cycle drain case
		end else if (outReady) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take) begin
			held <= inData;
		end
	end

	assign outValid = full;
	assign outData = held;

endmodule

`default_nettype wire

// File: verilog/videoStreamPkg.sv
// stream beat types pairing a pixel with its end-of-line marker
`default_nettype none

package videoStreamPkg;

	import cryPixelPkg::*;

	typedef struct packed {
		cryPixel_t pixel;
		logic      endOfLine; // last pixel of the scan line
	} cryBeat_t;

	typedef struct packed {
		rgb888_t rgb;
		logic    endOfLine;
	} rgbBeat_t;

endpackage

`default_nettype wire

// File: verilog/cryPixelPkg.sv
// CRY pixel format types shared by the colour conversion path
`default_nettype none

`include "cry_config.svh"

package cryPixelPkg;

	// one CRY pixel, the colour byte is {cyanIdx, redIdx}
	typedef struct packed {
		logic [3:0]                   cyanIdx;
		logic [3:0]                   redIdx;
		logic [`CRY_CHANNEL_BITS-1:0] intensity; // scales the looked-up colour
	} cryPixel_t;

	typedef struct packed {
		logic [`CRY_CHANNEL_BITS-1:0] red;
		logic [`CRY_CHANNEL_BITS-1:0] green;
		logic [`CRY_CHANNEL_BITS-1:0] blue;
	} rgb888_t;

	// selects which colour table a ROM instance holds
	typedef enum logic [1:0] {
		chanRed,
		chanGreen,
		chanBlue
	} cryChannel_t;

endpackage

`default_nettype wire

// File: include/cry_config.svh
// CRY colour stage sizing and timing constants
`ifndef CRY_CONFIG_SVH
`define CRY_CONFIG_SVH

// width of one RGB channel and of the CRY intensity byte
`define CRY_CHANNEL_BITS 8

// entries in each colour table, one per colour byte value
`define CRY_TABLE_DEPTH 256

// cycles from input acceptance to output valid with no back-pressure
// input stage, table read, intensity scale and output stage add one each
`define CRY_PIPE_LATENCY 4

`endif
